//--- Bender.yml
package:
  name: hc_root

sources:
  - files:
      - hw/hc_bus_pkg.sv
      - hw/hc_csr_pkg.sv
      - hw/hc_line_if.sv
      - hw/hc_csr_decode.sv
      - hw/hc_fifo_from_host.sv
      - hw/hc_tester.sv
      - hw/hc_fifo_to_host.sv
      - hw/hc_root.sv
  - target: simulation
    files:
      - testbench/hc_root_chk.sv
      - testbench/hc_root_tb.sv

//--- hw/hc_bus_pkg.sv
// Host bus types shared by the host channel driver: data lines, addresses and inbound messages
package hc_bus_pkg;

    // =====================================================================
    // Data lines and addresses
    // =====================================================================

    // One data line carries a full 64-bit payload
    localparam int LINE_W = 64;

    typedef logic [LINE_W-1:0] t_hc_line;

    // Host write addresses count in whole lines
    typedef logic [31:0] t_hc_addr;

    // =====================================================================
    // Inbound messages
    // =====================================================================

    // The kind bit says how the message word must be read
    typedef logic t_hc_msg_kind;

    localparam t_hc_msg_kind HC_KIND_CSR  = 1'b0;
    localparam t_hc_msg_kind HC_KIND_RESP = 1'b1;

    // A control register write packs the register address above its value
    typedef struct packed
    {
        logic [15:0] addr;
        logic [47:0] value;
    } t_hc_csr_wr;

    // The same 64-bit word is either a register write or a read response line
    typedef union packed
    {
        t_hc_csr_wr csr;
        t_hc_line   line;
    } t_hc_msg;

endpackage

//--- hw/hc_csr_decode.sv
// Decode stage that registers inbound host messages, splits them by kind and holds the CSRs
module hc_csr_decode import hc_bus_pkg::*, hc_csr_pkg::*;
#(
    // Start of the control register region on the host bus
    parameter logic [15:0] CSR_BASE_ADDR = 16'h0100
)
(
    input  logic         clk,
    input  logic         reset,

    input  logic         rx_valid,
    input  t_hc_msg_kind rx_kind,
    input  t_hc_msg      rx_msg,

    hc_line_if.source    resp,

    output t_hc_mode     mode,
    output t_hc_addr     buf_base,
    output logic         base_written
);

    // =====================================================================
    // Inbound message register
    // =====================================================================

    logic         msg_valid_q;
    t_hc_msg_kind msg_kind_q;
    t_hc_msg      msg_q;

    // A registered response that has not been taken yet must stay put
    logic resp_stall;

    assign resp_stall = resp.valid && !resp.ready;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            msg_valid_q <= 1'b0;
        end
        else if (!resp_stall)
        begin
            msg_valid_q <= rx_valid;
        end
    end

    // Payload of the stage needs no reset, the valid bit qualifies it
    always_ff @(posedge clk)
    begin
        if (!resp_stall)
        begin
            msg_kind_q <= rx_kind;
            msg_q      <= rx_msg;
        end
    end

    // =====================================================================
    // Read responses
    // =====================================================================

    // A read response is the message word read as a data line
    assign resp.valid = msg_valid_q && (msg_kind_q == HC_KIND_RESP);
    assign resp.data  = msg_q.line;

    // =====================================================================
    // Control registers
    // =====================================================================

    logic csr_write;
    logic hit_mode;
    logic hit_base;

    // The same word read as a register write, only for the CSR kind
    assign csr_write = msg_valid_q && (msg_kind_q == HC_KIND_CSR);
    assign hit_mode  = csr_write && (msg_q.csr.addr == CSR_BASE_ADDR + HC_CSR_MODE);
    assign hit_base  = csr_write && (msg_q.csr.addr == CSR_BASE_ADDR + HC_CSR_BUF_BASE);

    // Writes to any other address fall through without effect
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            mode         <= HC_PASS;
            buf_base     <= '0;
            base_written <= 1'b0;
        end
        else
        begin
            if (hit_mode)
            begin
                mode <= t_hc_mode'(msg_q.csr.value[0]);
            end

            if (hit_base)
            begin
                buf_base <= msg_q.csr.value[31:0];
            end

            // Pulses in the same cycle the new base becomes visible
            base_written <= hit_base;
        end
    end

endmodule

//--- hw/hc_csr_pkg.sv
// Control register map of the host channel driver and the driver mode encoding
package hc_csr_pkg;

    // =====================================================================
    // Register offsets from the control register base
    // =====================================================================

    // Mode register, bit 0 selects pass-through or loopback
    localparam logic [15:0] HC_CSR_MODE = 16'h0000;

    // Buffer base register, the low 32 bits give the first write address
    localparam logic [15:0] HC_CSR_BUF_BASE = 16'h0001;

    // =====================================================================
    // Driver mode
    // =====================================================================

    // Pass-through connects host and client, loopback turns read
    // responses straight around into host writes
    typedef enum logic
    {
        HC_PASS = 1'b0,
        HC_LOOP = 1'b1
    } t_hc_mode;

endpackage

//--- hw/hc_fifo_from_host.sv
// Execute stage FIFO that buffers read response lines until the client drains them
module hc_fifo_from_host import hc_bus_pkg::*;
#(
    // Number of lines held, must be a power of two
    parameter int FIFO_DEPTH = 8
)
(
    input  logic     clk,
    input  logic     reset,

    hc_line_if.sink  in,

    output t_hc_line out_data,
    output logic     out_rdy,
    input  logic     out_enable
);

    localparam int PTR_W = $clog2(FIFO_DEPTH);

    // =====================================================================
    // Storage and pointers
    // =====================================================================

    t_hc_line mem [FIFO_DEPTH];

    // Pointers wrap on their own since the depth is a power of two
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;

    logic push;
    logic pop;

    // Ready drops only when every slot holds a line
    assign in.ready = (count != (PTR_W + 1)'(FIFO_DEPTH));
    assign push     = in.valid && in.ready;

    // The client sees the head line and pops it in the same cycle
    assign out_rdy  = (count != '0);
    assign out_data = mem[rd_ptr];
    assign pop      = out_enable && out_rdy;

    always_ff @(posedge clk)
    begin
        if (push)
        begin
            mem[wr_ptr] <= in.data;
        end
    end

    // =====================================================================
    // Occupancy tracking
    // =====================================================================

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (push)
            begin
                wr_ptr <= wr_ptr + 1'b1;
            end

            if (pop)
            begin
                rd_ptr <= rd_ptr + 1'b1;
            end

            // Simultaneous push and pop leaves the count alone
            if (push && !pop)
            begin
                count <= count + 1'b1;
            end
            else if (pop && !push)
            begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

//--- hw/hc_fifo_to_host.sv
// Result stage FIFO that buffers outgoing lines and issues registered host write requests
module hc_fifo_to_host import hc_bus_pkg::*;
#(
    // Number of lines held, must be a power of two
    parameter int FIFO_DEPTH = 8
)
(
    input  logic     clk,
    input  logic     reset,

    hc_line_if.sink  in,

    input  t_hc_addr buf_base,
    input  logic     base_written,

    input  logic     almost_full,
    output logic     tx_valid,
    output t_hc_addr tx_addr,
    output t_hc_line tx_data
);

    localparam int PTR_W = $clog2(FIFO_DEPTH);

    // =====================================================================
    // Storage and pointers
    // =====================================================================

    t_hc_line mem [FIFO_DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;

    logic push;
    logic pop;

    // Host back-pressure seen one cycle late
    logic almost_full_q;

    assign in.ready = (count != (PTR_W + 1)'(FIFO_DEPTH));
    assign push     = in.valid && in.ready;

    // With the flag registered one request can still slip out after it rises
    assign pop = (count != '0) && !almost_full_q;

    always_ff @(posedge clk)
    begin
        if (push)
        begin
            mem[wr_ptr] <= in.data;
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            wr_ptr        <= '0;
            rd_ptr        <= '0;
            count         <= '0;
            almost_full_q <= 1'b0;
        end
        else
        begin
            almost_full_q <= almost_full;

            if (push)
            begin
                wr_ptr <= wr_ptr + 1'b1;
            end

            if (pop)
            begin
                rd_ptr <= rd_ptr + 1'b1;
            end

            if (push && !pop)
            begin
                count <= count + 1'b1;
            end
            else if (pop && !push)
            begin
                count <= count - 1'b1;
            end
        end
    end

    // =====================================================================
    // Write addressing and host request register
    // =====================================================================

    t_hc_addr line_idx;
    t_hc_addr cur_idx;

    // A fresh base restarts numbering, even for a write leaving this cycle
    assign cur_idx = base_written ? '0 : line_idx;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            tx_valid <= 1'b0;
            line_idx <= '0;
        end
        else
        begin
            tx_valid <= pop;

            if (pop)
            begin
                line_idx <= cur_idx + 1'b1;
            end
            else if (base_written)
            begin
                line_idx <= '0;
            end
        end
    end

    // Address and data are qualified by tx_valid
    always_ff @(posedge clk)
    begin
        if (pop)
        begin
            tx_addr <= buf_base + cur_idx;
            tx_data <= mem[rd_ptr];
        end
    end

endmodule

//--- hw/hc_line_if.sv
// Valid/ready channel that moves one data line between host channel driver blocks
interface hc_line_if import hc_bus_pkg::*; ();

    // A line moves in every cycle where valid and ready are both high
    logic     valid;
    logic     ready;
    t_hc_line data;

    // The source holds valid and data steady until the sink takes the line
    modport source
    (
        output valid,
        output data,
        input  ready
    );

    // The sink only answers with ready
    modport sink
    (
        input  valid,
        input  data,
        output ready
    );

endinterface

//--- hw/hc_root.sv
// Top level of the host channel driver, joining decode, routing and both FIFOs to plain ports
module hc_root import hc_bus_pkg::*, hc_csr_pkg::*;
#(
    parameter logic [15:0] CSR_BASE_ADDR = 16'h0100,
    parameter int          FIFO_DEPTH    = 8
)
(
    input  logic         clk,
    input  logic         reset,

    // Inbound host messages
    input  logic         rx_valid,
    input  t_hc_msg_kind rx_kind,
    input  t_hc_msg      rx_msg,

    // Outbound host write requests
    output logic         tx_valid,
    output t_hc_addr     tx_addr,
    output t_hc_line     tx_data,
    input  logic         tx_almost_full,

    // Client receive FIFO
    output t_hc_line     rx_fifo_data,
    output logic         rx_fifo_rdy,
    input  logic         rx_fifo_enable,

    // Client transmit FIFO
    input  t_hc_line     tx_fifo_data,
    output logic         tx_fifo_rdy,
    input  logic         tx_fifo_enable
);

    // =====================================================================
    // Internal line channels
    // =====================================================================

    hc_line_if resp_line ();
    hc_line_if rx_line ();
    hc_line_if client_tx_line ();
    hc_line_if out_line ();

    t_hc_mode mode;
    t_hc_addr buf_base;
    logic     base_written;

    // The client enable doubles as valid since it only fires while ready
    assign client_tx_line.valid = tx_fifo_enable;
    assign client_tx_line.data  = tx_fifo_data;
    assign tx_fifo_rdy          = client_tx_line.ready;

    // =====================================================================
    // Driver blocks
    // =====================================================================

    hc_csr_decode #(
        .CSR_BASE_ADDR (CSR_BASE_ADDR)
    ) csr_decode (
        .clk          (clk),
        .reset        (reset),
        .rx_valid     (rx_valid),
        .rx_kind      (rx_kind),
        .rx_msg       (rx_msg),
        .resp         (resp_line.source),
        .mode         (mode),
        .buf_base     (buf_base),
        .base_written (base_written)
    );

    // Mode decides where responses and client lines end up
    hc_tester tester (
        .mode      (mode),
        .resp      (resp_line.sink),
        .client_tx (client_tx_line.sink),
        .to_client (rx_line.source),
        .to_host   (out_line.source)
    );

    hc_fifo_from_host #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) fifo_from_host (
        .clk        (clk),
        .reset      (reset),
        .in         (rx_line.sink),
        .out_data   (rx_fifo_data),
        .out_rdy    (rx_fifo_rdy),
        .out_enable (rx_fifo_enable)
    );

    hc_fifo_to_host #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) fifo_to_host (
        .clk          (clk),
        .reset        (reset),
        .in           (out_line.sink),
        .buf_base     (buf_base),
        .base_written (base_written),
        .almost_full  (tx_almost_full),
        .tx_valid     (tx_valid),
        .tx_addr      (tx_addr),
        .tx_data      (tx_data)
    );

endmodule

//--- hw/hc_tester.sv
// Execute stage router that steers lines for pass-through or loopback operation
module hc_tester import hc_csr_pkg::*;
(
    input  t_hc_mode  mode,

    hc_line_if.sink   resp,
    hc_line_if.sink   client_tx,

    hc_line_if.source to_client,
    hc_line_if.source to_host
);

    // Purely combinational, ready follows whichever path is active
    always_comb
    begin
        // Idle defaults keep both outputs quiet and both inputs stalled
        to_client.valid = 1'b0;
        to_client.data  = resp.data;
        to_host.valid   = 1'b0;
        to_host.data    = client_tx.data;
        resp.ready      = 1'b0;
        client_tx.ready = 1'b0;

        if (mode == HC_PASS)
        begin
            // Read responses go to the client
            to_client.valid = resp.valid;
            resp.ready      = to_client.ready;

            // Client lines go out to the host
            to_host.valid   = client_tx.valid;
            client_tx.ready = to_host.ready;
        end
        else
        begin
            // Responses turn around toward the host, the client sees nothing
            // and its transmit side stays blocked
            to_host.valid = resp.valid;
            to_host.data  = resp.data;
            resp.ready    = to_host.ready;
        end
    end

endmodule

//--- list.f
hw/hc_bus_pkg.sv
hw/hc_csr_pkg.sv
hw/hc_line_if.sv
hw/hc_csr_decode.sv
hw/hc_fifo_from_host.sv
hw/hc_tester.sv
hw/hc_fifo_to_host.sv
hw/hc_root.sv
testbench/hc_root_chk.sv
testbench/hc_root_tb.sv

//--- testbench/hc_root_chk.sv
// Assertion checker bound to the host channel driver top level ports
module hc_root_chk
(
    input logic clk,
    input logic reset,
    input logic tx_valid,
    input logic tx_almost_full,
    input logic rx_fifo_rdy
);

    int unsigned fail_count = 0;

    tx_valid_known: assert property (@(posedge clk) disable iff (reset) !$isunknown(tx_valid))
    else
    begin
        $error("tx_valid is unknown after reset");
        fail_count++;
    end

    // From the second reset cycle on the client FIFO reads empty
    rx_rdy_in_reset: assert property (@(posedge clk) reset ##1 reset |-> !rx_fifo_rdy)
    else
    begin
        $error("rx_fifo_rdy is high during reset");
        fail_count++;
    end

    // Almost-full is registered once, so requests stop two cycles later
    af_stops_tx: assert property (@(posedge clk) disable iff (reset)
        tx_almost_full |-> ##2 !tx_valid)
    else
    begin
        $error("more than one host write issued after tx_almost_full rose");
        fail_count++;
    end

endmodule

bind hc_root hc_root_chk chk (
    .clk            (clk),
    .reset          (reset),
    .tx_valid       (tx_valid),
    .tx_almost_full (tx_almost_full),
    .rx_fifo_rdy    (rx_fifo_rdy)
);

//--- testbench/hc_root_tb.sv
// Testbench for the host channel driver, LFSR traffic checked against a queue model
module hc_root_tb import hc_bus_pkg::*, hc_csr_pkg::*;
();

    // ======================================================================
    // Configuration and run length
    // ======================================================================

    localparam logic [15:0] CSR_BASE_ADDR = 16'h0100;
    localparam int          FIFO_DEPTH    = 8;

    localparam int RESET_CYCLES = 16;
    localparam int PHASE_CYCLES = 120;
    localparam int N_PHASES     = 5;
    localparam int CSR_CYCLES   = 4;
    localparam int N_CSR        = 6;

    // Run length without draining, the limit leaves room for drains
    localparam int STIM_CYCLES    = RESET_CYCLES + N_PHASES * PHASE_CYCLES + N_CSR * CSR_CYCLES;
    localparam int TIMEOUT_CYCLES = 4 * STIM_CYCLES + 200;

    localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

    logic         clk;
    logic         reset;
    logic         rx_valid;
    t_hc_msg_kind rx_kind;
    t_hc_msg      rx_msg;
    logic         tx_valid;
    t_hc_addr     tx_addr;
    t_hc_line     tx_data;
    logic         tx_almost_full;
    t_hc_line     rx_fifo_data;
    logic         rx_fifo_rdy;
    logic         rx_fifo_enable;
    t_hc_line     tx_fifo_data;
    logic         tx_fifo_rdy;
    logic         tx_fifo_enable;

    hc_root #(
        .CSR_BASE_ADDR (CSR_BASE_ADDR),
        .FIFO_DEPTH    (FIFO_DEPTH)
    ) uut (
        .clk            (clk),
        .reset          (reset),
        .rx_valid       (rx_valid),
        .rx_kind        (rx_kind),
        .rx_msg         (rx_msg),
        .tx_valid       (tx_valid),
        .tx_addr        (tx_addr),
        .tx_data        (tx_data),
        .tx_almost_full (tx_almost_full),
        .rx_fifo_data   (rx_fifo_data),
        .rx_fifo_rdy    (rx_fifo_rdy),
        .rx_fifo_enable (rx_fifo_enable),
        .tx_fifo_data   (tx_fifo_data),
        .tx_fifo_rdy    (tx_fifo_rdy),
        .tx_fifo_enable (tx_fifo_enable)
    );

    // ======================================================================
    // Reference model state
    // ======================================================================

    // Lines on their way to the client and to the host, in order
    t_hc_line rx_q[$];
    t_hc_line tx_q[$];

    t_hc_mode    exp_mode    = HC_PASS;
    t_hc_addr    next_addr   = '0;
    logic        af_random   = 1'b0;
    logic        af_older    = 1'b0;
    logic [31:0] lfsr        = 32'h8b5b;
    int          errors      = 0;
    int          checks      = 0;
    int          cycle_count = 0;

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Galois step, one call per random bit
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        return state[0] ? ((state >> 1) ^ LFSR_TAPS) : (state >> 1);
    endfunction

    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] r;
        int          k;
        r = '0;
        for (k = 0; k < n; k++)
        begin
            lfsr = lfsr_next(lfsr);
            r    = {r[62:0], lfsr[0]};
        end
        return r;
    endfunction

    task automatic check(input logic [63:0] actual, input logic [63:0] expected,
                         input string what);
        checks++;
        if (actual !== expected)
        begin
            errors++;
            $display("CHECK FAILED at %0t: %s, got %h expected %h", $time, what, actual, expected);
        end
    endtask

    // ======================================================================
    // Per-cycle monitor and client behaviour
    // ======================================================================

    task automatic observe_outputs();
        t_hc_line exp_data;
        check($isunknown(tx_valid), 1'b0, "tx_valid is known");

        // Almost-full seen two cycles back has reached the request register
        if (af_older)
        begin
            check(tx_valid, 1'b0, "tx_valid held off by almost-full");
        end

        if (tx_valid === 1'b1)
        begin
            if (tx_q.size() == 0)
            begin
                errors++;
                $display("Host write request at %0t with no line waiting to go out", $time);
            end
            else
            begin
                exp_data = tx_q.pop_front();
                check(tx_data, exp_data, "host write data");
                check(tx_addr, next_addr, "host write address");
                next_addr++;
            end
        end
        af_older = tx_almost_full;
    endtask

    // The client pops at random gaps and sees the head line in the same cycle
    task automatic drain_client();
        rx_fifo_enable = 1'b0;
        if (rx_fifo_rdy === 1'b1 && rand_bits(2) != 0)
        begin
            if (rx_q.size() == 0)
            begin
                errors++;
                $display("Client FIFO offered a line at %0t that was never sent", $time);
            end
            else
            begin
                check(rx_fifo_data, rx_q.pop_front(), "client read data");
                rx_fifo_enable = 1'b1;
            end
        end
    endtask

    // Inputs change 2 units after the rising edge, outputs are settled by then
    task automatic next_cycle();
        @(posedge clk);
        #2;
        observe_outputs();
        drain_client();
        tx_almost_full = af_random ? (rand_bits(1) != 0) : 1'b0;
        rx_valid       = 1'b0;
        tx_fifo_enable = 1'b0;
    endtask

    task automatic wait_idle();
        while (rx_q.size() != 0 || tx_q.size() != 0)
        begin
            next_cycle();
        end
    endtask

    // ======================================================================
    // Stimulus
    // ======================================================================

    task automatic write_csr(input logic [15:0] addr, input logic [47:0] value);
        wait_idle();
        next_cycle();
        rx_valid          = 1'b1;
        rx_kind           = HC_KIND_CSR;
        rx_msg.csr.addr   = addr;
        rx_msg.csr.value  = value;
        // Registers change two cycles after the message
        repeat (CSR_CYCLES - 1) next_cycle();
        if (addr == CSR_BASE_ADDR + HC_CSR_MODE)
        begin
            exp_mode = t_hc_mode'(value[0]);
        end
        else if (addr == CSR_BASE_ADDR + HC_CSR_BUF_BASE)
        begin
            next_addr = value[31:0];
        end
    endtask

    task automatic run_traffic(input logic send_resp, input logic send_client, input logic af_on);
        t_hc_line data;
        logic     room;
        int       i;
        af_random = af_on;
        for (i = 0; i < PHASE_CYCLES; i++)
        begin
            next_cycle();
            if (exp_mode == HC_LOOP)
            begin
                check(rx_fifo_rdy, 1'b0, "rx_fifo_rdy in loopback");
                check(tx_fifo_rdy, 1'b0, "tx_fifo_rdy in loopback");
            end

            // Counting lines still in flight keeps the response path from stalling
            room = (exp_mode == HC_LOOP) ? (tx_q.size() < FIFO_DEPTH) : (rx_q.size() < FIFO_DEPTH);
            if (send_resp && room && rand_bits(1) != 0)
            begin
                data        = rand_bits(64);
                rx_valid    = 1'b1;
                rx_kind     = HC_KIND_RESP;
                rx_msg.line = data;
                if (exp_mode == HC_LOOP)
                begin
                    tx_q.push_back(data);
                end
                else
                begin
                    rx_q.push_back(data);
                end
            end

            if (send_client && tx_fifo_rdy === 1'b1 && rand_bits(1) != 0)
            begin
                tx_fifo_enable = 1'b1;
                tx_fifo_data   = rand_bits(64);
                tx_q.push_back(tx_fifo_data);
            end
        end
        af_random = 1'b0;
        wait_idle();
    endtask

    initial
    begin
        logic [63:0] r;
        reset          = 1'b1;
        rx_valid       = 1'b0;
        rx_kind        = HC_KIND_CSR;
        rx_msg         = '0;
        tx_almost_full = 1'b0;
        rx_fifo_enable = 1'b0;
        tx_fifo_data   = '0;
        tx_fifo_enable = 1'b0;

        repeat (RESET_CYCLES)
        begin
            @(posedge clk);
            #2;
            check(rx_fifo_rdy, 1'b0, "rx_fifo_rdy during reset");
        end
        reset = 1'b0;
        check(tx_valid, 1'b0, "tx_valid after reset");
        check(rx_fifo_rdy, 1'b0, "rx_fifo_rdy after reset");
        check(tx_fifo_rdy, 1'b1, "tx_fifo_rdy after reset");

        // Pass-through responses to the client
        run_traffic(1'b1, 1'b0, 1'b0);

        // New base, then client lines out to the host
        r = rand_bits(48);
        write_csr(CSR_BASE_ADDR + HC_CSR_BUF_BASE, r[47:0]);
        run_traffic(1'b0, 1'b1, 1'b0);

        // Loopback, then both directions under random back-pressure
        write_csr(CSR_BASE_ADDR + HC_CSR_MODE, 48'h1);
        run_traffic(1'b1, 1'b0, 1'b0);
        write_csr(CSR_BASE_ADDR + HC_CSR_MODE, 48'h0);
        run_traffic(1'b1, 1'b1, 1'b1);

        // Unknown offsets must not touch mode or base
        write_csr(CSR_BASE_ADDR + 16'h0002, 48'h1);
        write_csr(CSR_BASE_ADDR + 16'h0010, 48'hffff_ffff_ffff);
        write_csr(16'h0000, 48'h1);
        check(tx_fifo_rdy, 1'b1, "tx_fifo_rdy after ignored writes");
        run_traffic(1'b1, 1'b1, 1'b1);

        errors += uut.chk.fail_count;
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0)
        begin
            $display("sim passed");
        end
        else
        begin
            $display("sim failed");
        end
        $finish;
    end

    // Watchdog on the total cycle count
    initial
    begin
        while (cycle_count < TIMEOUT_CYCLES)
        begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout: the test did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("sim failed");
        $finish;
    end

endmodule
